// File: mipsProcessor.f
verilog/mipsIsaPkg.sv
verilog/mipsMachinePkg.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/byteBank.sv
verilog/memoryPort.sv
verilog/mipsController.sv
verilog/mipsDatapath.sv
verilog/mipsProcessor.sv
bench/mipsChecker.sv
bench/tbMipsProcessor.sv

// File: bench/tbMipsProcessor.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsProcessor;
	import mipsIsaPkg::*;
	import mipsMachinePkg::*;

	localparam int programLength = 48; // Instructions before the halt word
	localparam int imageWords = (2**addrWidth) / laneCount; // 128 words loaded
	localparam int timeoutCycles = imageWords + programLength * 12 + 100;

	logic CLK = 1'b0;
	logic reset, start, loadWrite;
	byteAddr_t loadAddress;
	word_t loadData;
	retire_t retire;
	store_t store;
	logic halted;
	logic finished; // Checker done with its report
	int failureCount;
	word_t image [imageWords];
	logic [31:0] lfsrState;
	int cycleCount = 0;

	always #5 CLK = ~CLK; // 10 ns period

	mipsProcessor mipsProcessor_inst (
		.CLK, .reset, .start, .loadWrite, .loadAddress, .loadData,
		.retire, .store, .halted
	);

	mipsChecker checker_inst (
		.CLK, .reset, .loadWrite, .loadAddress, .loadData,
		.retire, .store, .halted, .finished, .failureCount
	);

	//////////////////////////////
	// Random program
	//////////////////////////////
	function logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]}; // One step per bit
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
		end
		return bits;
	endfunction

	function regIndex_t pickDest();
		regIndex_t d;
		d = regIndex_t'(takeBits(3));
		return (d == 5'd3) ? 5'd0 : d; // r3 is the base, redirected to r0
	endfunction

	function word_t encodeR(input regIndex_t rs, rt, rd, input logic [4:0] sh,
			input logic [5:0] fn);
		return {opSpecial, rs, rt, rd, sh, fn};
	endfunction

	function word_t encodeI(input logic [5:0] op, input regIndex_t rs, rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task buildProgram();
		int n;
		logic [3:0] kind;
		logic [2:0] sel;
		logic [7:0] offset;
		regIndex_t rs, rt, dest;
		logic [5:0] aluFuncts [8];
		logic [5:0] shiftFuncts [3];
		logic [5:0] immOps [6];
		aluFuncts = '{functAdd, functSub, functAnd, functOr,
			functXor, functNor, functSlt, functSltu};
		shiftFuncts = '{functSll, functSrl, functSra};
		immOps = '{opAddi, opSlti, opAndi, opOri, opXori, opLui};
		for (int w = 0; w < imageWords; w++) begin
			image[w] = {7'h55, byteAddr_t'(w * 4), 7'h2A, byteAddr_t'(w * 4)}; // Whole address
		end
		image[0] = encodeI(opLui, 5'd0, 5'd1, {1'b1, 15'(takeBits(15))}); // Negative r1
		image[1] = encodeI(opOri, 5'd1, 5'd1, 16'(takeBits(16)));
		image[2] = encodeI(opLui, 5'd0, 5'd2, {1'b0, 15'(takeBits(15))}); // Positive r2
		image[3] = encodeI(opOri, 5'd2, 5'd2, 16'(takeBits(16)));
		image[4] = encodeI(opAddi, 5'd0, 5'd3, 16'h0100); // Data base, upper half
		image[5] = encodeR(5'd1, 5'd2, 5'd4, 5'd0, functSlt); // Mixed signs
		image[6] = encodeR(5'd1, 5'd2, 5'd5, 5'd0, functSltu);
		image[7] = encodeI(opAddi, 5'd1, 5'd0, 16'h0007); // Write to r0
		image[8] = encodeR(5'd0, 5'd2, 5'd6, 5'd0, functAdd); // r0 read back
		n = 9;
		while (n < programLength) begin
			kind = 4'(takeBits(4));
			if (kind >= 12 && n > programLength - 2) kind = 4'd0; // No room for a pair
			rs = regIndex_t'(takeBits(3));
			rt = regIndex_t'(takeBits(3));
			dest = pickDest();
			if (kind < 6) begin
				sel = 3'(takeBits(3));
				image[n] = encodeR(rs, rt, dest, 5'd0, aluFuncts[sel]);
				n++;
			end else if (kind < 8) begin
				sel = 3'(takeBits(3) % 3);
				image[n] = encodeR(5'd0, rt, dest, 5'(takeBits(5)), shiftFuncts[sel]);
				n++;
			end else if (kind < 12) begin
				sel = 3'(takeBits(3) % 6);
				image[n] = encodeI(immOps[sel], rs, dest, 16'(takeBits(16)));
				n++;
			end else begin
				offset = {6'(takeBits(6)), 2'b00};
				if (kind < 14) image[n] = encodeI(opSw, 5'd3, rt, {8'h00, offset});
				else image[n] = encodeI(opSb, 5'd3, rt, {8'h00, offset | 8'(takeBits(2))});
				image[n + 1] = encodeI(opLw, 5'd3, dest, {8'h00, offset}); // Same word back
				n += 2;
			end
		end
		image[programLength] = 32'hFC00_0000; // Opcode 3F halts
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		reset = 1'b1;
		start = 1'b0;
		loadWrite = 1'b0;
		loadAddress = '0;
		loadData = '0;
		lfsrState = 32'h2936;
		buildProgram();
		repeat (3) @(negedge CLK);
		reset = 1'b0;
		for (int w = 0; w < imageWords; w++) begin
			@(negedge CLK);
			loadWrite = 1'b1;
			loadAddress = byteAddr_t'(w * laneCount);
			loadData = image[w];
		end
		@(negedge CLK);
		loadWrite = 1'b0;
		start = 1'b1; // Run from address 0
		@(negedge CLK);
		start = 1'b0;
		wait (finished === 1'b1);
		@(negedge CLK);
		if (failureCount == 0) $display("No errors");
		else $display("Errors found");
		$finish;
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: processor did not halt within %0d cycles", timeoutCycles);
			$display("Errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/mipsChecker.sv
`timescale 1ns/1ps
`default_nettype none

module mipsChecker (
	input logic CLK,
	input logic reset,
	input logic loadWrite,
	input mipsMachinePkg::byteAddr_t loadAddress,
	input mipsIsaPkg::word_t loadData,
	input mipsMachinePkg::retire_t retire,
	input mipsMachinePkg::store_t store,
	input logic halted,
	output logic finished,
	output int failureCount
);
	import mipsIsaPkg::*;
	import mipsMachinePkg::*;

	localparam int settleCycles = 4; // Halt must hold this long

	typedef enum logic [1:0] {evRetire, evStore, evHalt} eventKind_t;

	typedef struct packed {
		eventKind_t kind;
		regIndex_t destination;
		word_t value; // Store data for evStore
		byteAddr_t address;
		laneMask_t byteEnable;
	} modelEvent_t;

	byte_t modelMem [2**addrWidth];
	word_t modelRegs [32];
	byteAddr_t modelPc;
	logic modelHalted, haltSeen;
	word_t lastWord; // Last fetched by the model
	modelEvent_t haltEvent; // Model step when the DUT halts
	int testCount, passCount, dutEvents, modelEvents, settle;

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function word_t readWord(input byteAddr_t a);
		return {modelMem[a], modelMem[a + 1], modelMem[a + 2], modelMem[a + 3]}; // Big endian
	endfunction

	function void writeWord(input byteAddr_t a, input word_t d);
		for (int i = 0; i < 4; i++) modelMem[a + i] = d[31 - 8 * i -: 8];
	endfunction

	function logic lessSigned(input word_t a, input word_t b);
		if (a[31] != b[31]) return a[31]; // Negative one is smaller
		return a < b;
	endfunction

	function word_t shiftRightArith(input word_t v, input logic [4:0] n);
		return (v >> n) | (v[31] ? ~(32'hFFFF_FFFF >> n) : 32'h0);
	endfunction

	function string mnemonic(input word_t w);
		if (w[31:26] == 6'h00) begin
			case (w[5:0])
				6'h20: return "add";
				6'h22: return "sub";
				6'h24: return "and";
				6'h25: return "or";
				6'h26: return "xor";
				6'h27: return "nor";
				6'h2A: return "slt";
				6'h2B: return "sltu";
				6'h00: return "sll";
				6'h02: return "srl";
				6'h03: return "sra";
				default: return "r-type?";
			endcase
		end
		case (w[31:26])
			6'h08: return "addi";
			6'h0A: return "slti";
			6'h0C: return "andi";
			6'h0D: return "ori";
			6'h0E: return "xori";
			6'h0F: return "lui";
			6'h23: return "lw";
			6'h2B: return "sw";
			6'h28: return "sb";
			default: return "illegal";
		endcase
	endfunction

	// Runs one instruction on the model state and returns its event
	function modelEvent_t executeNext();
		word_t w, rsVal, rtVal, sext, zext, result;
		byteAddr_t addr;
		modelEvent_t ev;
		ev = '0;
		ev.kind = evHalt;
		if (modelHalted) return ev;
		w = readWord(modelPc);
		lastWord = w;
		modelPc = modelPc + 9'd4; // Wraps at 512
		rsVal = modelRegs[w[25:21]];
		rtVal = modelRegs[w[20:16]];
		sext = {{16{w[15]}}, w[15:0]};
		zext = {16'h0000, w[15:0]};
		addr = byteAddr_t'(rsVal + sext); // Truncated to memory size
		result = '0;
		ev.kind = evRetire;
		ev.destination = w[20:16];
		case (w[31:26])
			6'h00: begin
				ev.destination = w[15:11];
				case (w[5:0])
					6'h20: result = rsVal + rtVal;
					6'h22: result = rsVal - rtVal;
					6'h24: result = rsVal & rtVal;
					6'h25: result = rsVal | rtVal;
					6'h26: result = rsVal ^ rtVal;
					6'h27: result = ~(rsVal | rtVal);
					6'h2A: result = word_t'(lessSigned(rsVal, rtVal));
					6'h2B: result = word_t'(rsVal < rtVal);
					6'h00: result = rtVal << w[10:6];
					6'h02: result = rtVal >> w[10:6];
					6'h03: result = shiftRightArith(rtVal, w[10:6]);
					default: ev.kind = evHalt;
				endcase
			end
			6'h08: result = rsVal + sext;
			6'h0A: result = word_t'(lessSigned(rsVal, sext));
			6'h0C: result = rsVal & zext; // Logic immediates zero-extend
			6'h0D: result = rsVal | zext;
			6'h0E: result = rsVal ^ zext;
			6'h0F: result = {w[15:0], 16'h0000};
			6'h23: result = readWord({addr[8:2], 2'b00});
			6'h2B: begin
				ev.kind = evStore;
				ev.address = {addr[8:2], 2'b00};
				ev.value = rtVal;
				ev.byteEnable = 4'hF;
				writeWord(ev.address, rtVal);
			end
			6'h28: begin
				ev.kind = evStore;
				ev.address = addr;
				ev.value = {4{rtVal[7:0]}};
				ev.byteEnable = 4'b1000 >> addr[1:0]; // Offset 0 is the top byte
				modelMem[addr] = rtVal[7:0];
			end
			default: ev.kind = evHalt;
		endcase
		if (ev.kind == evRetire) begin
			ev.value = result;
			if (ev.destination != 5'd0) modelRegs[ev.destination] = result;
			modelEvents++;
		end else if (ev.kind == evStore) begin
			modelEvents++;
		end else begin
			modelHalted = 1'b1;
		end
		return ev;
	endfunction

	//////////////////////////////
	// Comparison
	//////////////////////////////
	task reportFailure(input string line);
		$display("%s", line);
		failureCount++;
	endtask

	task checkEvent();
		modelEvent_t ev;
		string name;
		ev = executeNext();
		testCount++;
		dutEvents++;
		name = $sformatf("instr %0d %s", testCount, mnemonic(lastWord));
		if (retire.valid && store.valid) begin
			reportFailure($sformatf("%s: retire and store were valid in the same cycle", name));
		end else if (ev.kind == evHalt) begin
			reportFailure($sformatf("%s: the DUT produced an event after the halt word", name));
		end else if (retire.valid && ev.kind != evRetire) begin
			reportFailure($sformatf("%s: the DUT wrote a register where a store was due", name));
		end else if (store.valid && ev.kind != evStore) begin
			reportFailure($sformatf("%s: the DUT stored where a register write was due", name));
		end else if (retire.valid && (retire.destination != ev.destination ||
				retire.value != ev.value)) begin
			reportFailure($sformatf("FAILED %s expected r%0d=%08h actual r%0d=%08h", name,
				ev.destination, ev.value, retire.destination, retire.value));
		end else if (store.valid && (store.address != ev.address ||
				store.data != ev.value || store.byteEnable != ev.byteEnable)) begin
			reportFailure($sformatf(
				"FAILED %s expected [%03h]=%08h be %04b actual [%03h]=%08h be %04b",
				name, ev.address, ev.value, ev.byteEnable,
				store.address, store.data, store.byteEnable));
		end else begin
			$display("ok     %s", name);
			passCount++;
		end
	endtask

	always @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) modelRegs[i] = '0;
			modelPc = '0;
			{modelHalted, haltSeen, finished} = '0;
			{testCount, passCount, failureCount, dutEvents, modelEvents, settle} = '0;
		end else begin
			if (loadWrite) writeWord({loadAddress[8:2], 2'b00}, loadData); // Own image
			if (retire.valid || store.valid) begin
				if (haltSeen) reportFailure("An event appeared after the processor halted");
				else checkEvent();
			end
			if (halted && !haltSeen) begin
				haltSeen = 1'b1;
				testCount++;
				haltEvent = executeNext();
				if (haltEvent.kind != evHalt || dutEvents != modelEvents) begin
					reportFailure("halt: the DUT halted before the model reached the halt word");
				end else begin
					$display("ok     halt after %0d events", dutEvents);
					passCount++;
				end
			end else if (haltSeen && !finished) begin
				settle++;
				if (!halted) reportFailure("halted dropped before reset");
				if (settle == settleCycles) begin
					$display(
						"%0d tests, %0d passed, %0d failed, %0d DUT events, %0d model events",
						testCount, passCount, failureCount, dutEvents, modelEvents);
					finished = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mipsProcessor.sv
`timescale 1ns/1ps
`default_nettype none

module mipsProcessor (
	input logic CLK,
	input logic reset,
	input logic start,
	input logic loadWrite,
	input mipsMachinePkg::byteAddr_t loadAddress,
	input mipsIsaPkg::word_t loadData,
	output mipsMachinePkg::retire_t retire,
	output mipsMachinePkg::store_t store,
	output logic halted
);
	import mipsIsaPkg::*;
	import mipsMachinePkg::*;

	ctrl_t ctrl; // Controller to datapath
	instr_t instruction; // IR contents
	memRequest_t memRequest;
	logic memDone;
	logic [laneCount-1:0] laneWrite; // Indexed by lane
	bankIndex_t laneIndex; // Shared by all banks
	byte_t laneData [laneCount];
	byte_t readLane [laneCount];

	mipsController controller_inst (
		.CLK, .reset, .start, .instruction, .memDone, .ctrl, .halted
	);

	mipsDatapath datapath_inst (
		.CLK, .reset, .ctrl, .readLane, .memDone, .instruction, .memRequest, .retire, .store
	);

	memoryPort memoryPort_inst (
		.CLK, .reset, .loadWrite, .loadAddress, .loadData, .request(memRequest),
		.laneWrite, .laneIndex, .laneData, .memDone
	);

	//////////////////////////////
	// Byte banks
	//////////////////////////////
	for (genvar lane = 0; lane < laneCount; lane++) begin : bankGen
		byteBank bank_inst (
			.CLK,
			.write(laneWrite[lane]),
			.index(laneIndex),
			.writeByte(laneData[lane]),
			.readByte(readLane[lane])
		);
	end

endmodule

`default_nettype wire

// File: verilog/mipsDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module mipsDatapath (
	input logic CLK,
	input logic reset,
	input mipsMachinePkg::ctrl_t ctrl,
	input mipsMachinePkg::byte_t readLane [mipsMachinePkg::laneCount],
	input logic memDone,
	output mipsIsaPkg::instr_t instruction,
	output mipsMachinePkg::memRequest_t memRequest,
	output mipsMachinePkg::retire_t retire,
	output mipsMachinePkg::store_t store
);
	import mipsIsaPkg::*;
	import mipsMachinePkg::*;

	byteAddr_t pc;
	word_t joined; // Lanes put back together
	word_t mdr;
	word_t dataA, dataB;
	word_t immSigned, immExt, operandB;
	word_t addrSum, aluResult, storeData;
	byteAddr_t dataAddress;
	laneMask_t byteMask;
	regIndex_t destination;

	//////////////////////////////
	// Registers
	//////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.pcAdvance) begin
			pc <= pc + byteAddr_t'(laneCount); // Wraps at 512
		end
	end

	always_comb begin
		for (int lane = 0; lane < laneCount; lane++) begin
			joined[8*(laneCount-1-lane) +: 8] = readLane[lane]; // Lane 0 on top
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.irLoad && memDone) instruction <= joined;
		if (ctrl.mdrLoad && memDone) mdr <= joined;
	end

	registerFile registerFile_inst (
		.CLK, .reset,
		.readA(instruction.rs), .readB(instruction.rt),
		.dataA, .dataB,
		.write(ctrl.regWrite), .destination, .writeData(retire.value)
	);

	//////////////////////////////
	// Operands and ALU
	//////////////////////////////
	assign immSigned = {{16{instruction.low.imm[15]}}, instruction.low.imm};
	assign immExt = ctrl.immZeroExt ? {16'h0000, instruction.low.imm} : immSigned;
	assign operandB = ctrl.aluSrcImm ? immExt : dataB;

	alu alu_inst (
		.op(ctrl.aluOp), .a(dataA), .b(operandB),
		.shamt(instruction.low.r.shamt), .result(aluResult)
	);

	//////////////////////////////
	// Memory access
	//////////////////////////////
	assign addrSum = dataA + immSigned;
	assign dataAddress = addrSum[addrWidth-1:0]; // Truncated to memory size
	assign byteMask = {1'b1, {(laneCount-1){1'b0}}} >> dataAddress[laneBits-1:0];
	assign storeData = ctrl.byteStore ? {laneCount{dataB[7:0]}} : dataB; // sb copies byte

	always_comb begin
		memRequest.valid = ctrl.memRequest;
		memRequest.write = ctrl.memWrite;
		memRequest.data = storeData;
		if (ctrl.pcAdvance) begin // Fetch
			memRequest.address = pc;
			memRequest.byteEnable = '1;
		end else if (ctrl.byteStore) begin
			memRequest.address = dataAddress;
			memRequest.byteEnable = byteMask;
		end else begin // Word access, aligned
			memRequest.address = {dataAddress[addrWidth-1:laneBits], {laneBits{1'b0}}};
			memRequest.byteEnable = '1;
		end
	end

	assign store.valid = ctrl.memWrite;
	assign store.address = memRequest.address;
	assign store.data = storeData;
	assign store.byteEnable = memRequest.byteEnable;

	//////////////////////////////
	// Writeback
	//////////////////////////////
	assign destination = ctrl.destRt ? instruction.rt : instruction.low.r.rd;
	assign retire.valid = ctrl.regWrite;
	assign retire.destination = destination;
	assign retire.value = ctrl.regFromMem ? mdr : aluResult;

endmodule

`default_nettype wire

// File: verilog/mipsController.sv
`timescale 1ns/1ps
`default_nettype none

module mipsController (
	input logic CLK,
	input logic reset,
	input logic start,
	input mipsIsaPkg::instr_t instruction,
	input logic memDone,
	output mipsMachinePkg::ctrl_t ctrl,
	output logic halted
);
	import mipsIsaPkg::*;
	import mipsMachinePkg::*;

	ctrlState_t state, nextState;
	aluOp_t decAluOp, aluOp; // Combinational and held decode
	logic decImm, decZero, decRt, decLoad, decStore, decByte, decLegal;
	logic useImm, zeroExt, useRt, isLoad, isStore, isByte;

	//////////////////////////////
	// Instruction decode
	//////////////////////////////
	always_comb begin
		decAluOp = aluAdd; // Loads and stores compute their own address
		decImm = 1'b1;
		decZero = 1'b0;
		decRt = 1'b1;
		decLoad = 1'b0;
		decStore = 1'b0;
		decByte = 1'b0;
		decLegal = 1'b1;
		case (instruction.opcode)
			opSpecial: begin
				decImm = 1'b0;
				decRt = 1'b0; // Writes rd
				case (instruction.low.r.funct)
					functAdd: decAluOp = aluAdd;
					functSub: decAluOp = aluSub;
					functAnd: decAluOp = aluAnd;
					functOr: decAluOp = aluOr;
					functXor: decAluOp = aluXor;
					functNor: decAluOp = aluNor;
					functSlt: decAluOp = aluSlt;
					functSltu: decAluOp = aluSltu;
					functSll: decAluOp = aluSll;
					functSrl: decAluOp = aluSrl;
					functSra: decAluOp = aluSra;
					default: decLegal = 1'b0; // Unknown funct halts too
				endcase
			end
			opAddi: decAluOp = aluAdd;
			opSlti: decAluOp = aluSlt;
			opAndi: begin
				decAluOp = aluAnd;
				decZero = 1'b1;
			end
			opOri: begin
				decAluOp = aluOr;
				decZero = 1'b1;
			end
			opXori: begin
				decAluOp = aluXor;
				decZero = 1'b1;
			end
			opLui: decAluOp = aluLui;
			opLw: decLoad = 1'b1;
			opSw: decStore = 1'b1;
			opSb: begin
				decStore = 1'b1;
				decByte = 1'b1;
			end
			default: decLegal = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			aluOp <= aluAdd;
			{useImm, zeroExt, useRt, isLoad, isStore, isByte} <= '0;
		end else if (state == stDecode) begin // Held for the later states
			aluOp <= decAluOp;
			{useImm, zeroExt, useRt} <= {decImm, decZero, decRt};
			{isLoad, isStore, isByte} <= {decLoad, decStore, decByte};
		end
	end

	//////////////////////////////
	// State machine
	//////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stIdle: if (start) nextState = stFetch;
			stFetch: nextState = stFetchWait;
			stFetchWait: if (memDone) nextState = stDecode;
			stDecode: nextState = decLegal ? stExecute : stHalted;
			stExecute: nextState = (isLoad || isStore) ? stMemWait : stWriteBack;
			stMemWait: if (memDone) nextState = isLoad ? stWriteBack : stFetch;
			stWriteBack: nextState = stFetch;
			default: nextState = stHalted; // Held until reset
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (state)
			stFetch: begin
				ctrl.memRequest = 1'b1;
				ctrl.pcAdvance = 1'b1;
			end
			stFetchWait: ctrl.irLoad = 1'b1;
			stExecute: begin
				ctrl.memRequest = isLoad || isStore;
				ctrl.memWrite = isStore;
				ctrl.byteStore = isByte;
			end
			stMemWait: ctrl.mdrLoad = isLoad;
			stWriteBack: begin
				ctrl.regWrite = 1'b1;
				ctrl.regFromMem = isLoad;
			end
			default: ;
		endcase
		if (state inside {stExecute, stMemWait, stWriteBack}) begin // Operand controls
			ctrl.aluSrcImm = useImm;
			ctrl.immZeroExt = zeroExt;
			ctrl.destRt = useRt;
			ctrl.aluOp = aluOp;
		end
	end

	assign halted = (state == stHalted);

endmodule

`default_nettype wire

// File: verilog/memoryPort.sv
`timescale 1ns/1ps
`default_nettype none

module memoryPort (
	input logic CLK,
	input logic reset,
	input logic loadWrite,
	input mipsMachinePkg::byteAddr_t loadAddress,
	input mipsIsaPkg::word_t loadData,
	input mipsMachinePkg::memRequest_t request,
	output logic [mipsMachinePkg::laneCount-1:0] laneWrite,
	output mipsMachinePkg::bankIndex_t laneIndex,
	output mipsMachinePkg::byte_t laneData [mipsMachinePkg::laneCount],
	output logic memDone
);
	import mipsIsaPkg::*;
	import mipsMachinePkg::*;

	logic accepted; // Datapath request taken this cycle
	laneMask_t enable; // Word byte order
	word_t writeWord;
	bankIndex_t heldIndex; // Keeps the bank read pointed at the request
	logic [memLatency-1:0] doneShift;

	assign accepted = request.valid && !loadWrite; // Load port first

	always_comb begin
		if (loadWrite) begin
			enable = '1;
			writeWord = loadData;
			laneIndex = loadAddress[addrWidth-1:laneBits];
		end else if (request.valid) begin
			enable = request.write ? request.byteEnable : '0;
			writeWord = request.data;
			laneIndex = request.address[addrWidth-1:laneBits];
		end else begin
			enable = '0;
			writeWord = request.data;
			laneIndex = heldIndex;
		end
	end

	always_comb begin
		for (int lane = 0; lane < laneCount; lane++) begin
			laneWrite[lane] = enable[laneCount-1-lane]; // Lane 0 is the top bit
			laneData[lane] = writeWord[8*(laneCount-1-lane) +: 8];
		end
	end

	always_ff @(posedge CLK) begin
		if (accepted) heldIndex <= laneIndex;
	end

	//////////////////////////////
	// Completion timing
	//////////////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			doneShift <= '0;
		end else begin
			doneShift <= {doneShift[memLatency-2:0], accepted};
		end
	end

	assign memDone = doneShift[memLatency-1];

endmodule

`default_nettype wire

// File: verilog/byteBank.sv
`timescale 1ns/1ps
`default_nettype none

module byteBank (
	input logic CLK,
	input logic write,
	input mipsMachinePkg::bankIndex_t index,
	input mipsMachinePkg::byte_t writeByte,
	output mipsMachinePkg::byte_t readByte
);
	import mipsMachinePkg::*;

	byte_t mem [bankDepth];

	always_ff @(posedge CLK) begin
		if (write) mem[index] <= writeByte;
		readByte <= mem[index]; // Registered read, old data on a write
	end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input logic CLK,
	input logic reset,
	input mipsIsaPkg::regIndex_t readA,
	input mipsIsaPkg::regIndex_t readB,
	output mipsIsaPkg::word_t dataA,
	output mipsIsaPkg::word_t dataB,
	input logic write,
	input mipsIsaPkg::regIndex_t destination,
	input mipsIsaPkg::word_t writeData
);
	import mipsIsaPkg::*;

	word_t regs [32];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (write && destination != '0) begin // r0 stays zero
			regs[destination] <= writeData;
		end
	end

	assign dataA = regs[readA]; // Combinational reads
	assign dataB = regs[readB];

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input mipsIsaPkg::aluOp_t op,
	input mipsIsaPkg::word_t a,
	input mipsIsaPkg::word_t b,
	input logic [4:0] shamt,
	output mipsIsaPkg::word_t result
);
	import mipsIsaPkg::*;

	always_comb begin
		case (op)
			aluAdd: result = a + b; // Overflow ignored
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluNor: result = ~(a | b);
			aluSlt: result = {31'b0, $signed(a) < $signed(b)};
			aluSltu: result = {31'b0, a < b};
			aluSll: result = b << shamt;
			aluSrl: result = b >> shamt;
			aluSra: result = $signed(b) >>> shamt; // Sign bit copied in
			aluLui: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/mipsMachinePkg.sv
`default_nettype none

package mipsMachinePkg;

	//////////////////////////////
	// Memory geometry
	//////////////////////////////
	localparam int addrWidth = 9; // 512 bytes
	localparam int laneCount = 4; // Bytes per word
	localparam int laneBits = $clog2(laneCount); // Byte offset bits
	localparam int bankDepth = 128; // Words per bank
	localparam int bankIndexWidth = $clog2(bankDepth);
	localparam int memLatency = 2; // Request to memDone

	typedef logic [addrWidth-1:0] byteAddr_t;
	typedef logic [bankIndexWidth-1:0] bankIndex_t;
	typedef logic [7:0] byte_t;
	// Bit laneCount-1 enables lane 0, the most significant byte
	typedef logic [laneCount-1:0] laneMask_t;

	typedef struct packed {
		logic valid;
		logic write;
		laneMask_t byteEnable;
		byteAddr_t address;
		mipsIsaPkg::word_t data;
	} memRequest_t;

	typedef struct packed {
		logic irLoad; // Capture instruction on memDone
		logic pcAdvance; // PC + 4, also selects PC as address
		logic mdrLoad; // Capture load data on memDone
		logic memRequest;
		logic memWrite;
		logic byteStore; // sb instead of sw
		logic regWrite;
		logic regFromMem; // Writeback from MDR
		logic aluSrcImm;
		logic immZeroExt; // andi, ori, xori
		logic destRt; // I-type destination
		mipsIsaPkg::aluOp_t aluOp;
	} ctrl_t;

	typedef enum logic [2:0] {
		stIdle, stFetch, stFetchWait, stDecode,
		stExecute, stMemWait, stWriteBack, stHalted
	} ctrlState_t;

	typedef struct packed {
		logic valid;
		mipsIsaPkg::regIndex_t destination;
		mipsIsaPkg::word_t value;
	} retire_t;

	typedef struct packed {
		logic valid;
		byteAddr_t address;
		mipsIsaPkg::word_t data;
		laneMask_t byteEnable;
	} store_t;

endpackage

`default_nettype wire

// File: verilog/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	typedef logic [31:0] word_t; // Data word
	typedef logic [4:0] regIndex_t; // Register number

	typedef struct packed {
		regIndex_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t; // Low half of an R-type word

	typedef union packed {
		rFields_t r;
		logic [15:0] imm; // Immediate shares the R-type bits
	} lowFields_t;

	typedef struct packed {
		logic [5:0] opcode;
		regIndex_t rs;
		regIndex_t rt;
		lowFields_t low;
	} instr_t;

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	localparam logic [5:0] opSpecial = 6'h00; // R-type
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opSlti = 6'h0A;
	localparam logic [5:0] opAndi = 6'h0C;
	localparam logic [5:0] opOri = 6'h0D;
	localparam logic [5:0] opXori = 6'h0E;
	localparam logic [5:0] opLui = 6'h0F;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSb = 6'h28;
	localparam logic [5:0] opSw = 6'h2B;

	//////////////////////////////
	// Funct codes
	//////////////////////////////
	localparam logic [5:0] functSll = 6'h00;
	localparam logic [5:0] functSrl = 6'h02;
	localparam logic [5:0] functSra = 6'h03;
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr = 6'h25;
	localparam logic [5:0] functXor = 6'h26;
	localparam logic [5:0] functNor = 6'h27;
	localparam logic [5:0] functSlt = 6'h2A;
	localparam logic [5:0] functSltu = 6'h2B;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOp_t;

endpackage

`default_nettype wire
